// File: hdl/memAccessPkg.sv
`default_nettype none

package memAccessPkg;

    ////////////////////
    // Memory geometry
    ////////////////////

    // Width of one CPU word
    localparam int DATA_W = 32;

    // Byte lanes across a word, one RAM each
    localparam int LANES  = 4;
    localparam int BYTE_W = DATA_W / LANES;
    localparam int HALF_W = DATA_W / 2;

    // Words of storage per lane
    localparam int DEPTH  = 256;
    localparam int IDX_W  = $clog2(DEPTH);

    ////////////////////
    // APB address map
    ////////////////////

    localparam int ADDR_W = 16;

    // Byte offset within the addressed word
    localparam int OFFSET_LSB = 0;
    localparam int OFFSET_MSB = 1;

    // Word index, IDX_W bits starting here
    localparam int IDX_LSB = 2;

    // Bits 12..10 carry nothing and are ignored

    // Access size code, two bits starting here
    localparam int SIZE_LSB = 13;

    // Load sign extension request
    localparam int SIGN_BIT = 15;

    ////////////////////
    // Access size
    ////////////////////

    // Code 3 is reserved and always answered with an error
    typedef enum logic [1:0] {
        SIZE_WORD = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_BYTE = 2'd2,
        SIZE_RSVD = 2'd3
    } accessSize_t;

endpackage

`default_nettype wire

// File: hdl/memReqIf.sv
`default_nettype none

interface memReqIf;
    import memAccessPkg::*;

    // Single-cycle strobes, never high together
    logic                         wr;
    logic                         rd;

    // Decoded address fields
    logic [IDX_W-1:0]             wordIdx;
    accessSize_t                  size;
    logic                         signExt;
    logic [OFFSET_MSB:OFFSET_LSB] offset;

    // Store data as seen on the bus, load data after extension
    logic [DATA_W-1:0]            wrData;
    logic [DATA_W-1:0]            rdData;

    // APB side decodes the access and collects the result
    modport port (
        output wr, rd, wordIdx, size, signExt, offset, wrData,
        input  rdData
    );

    modport store (
        input wr, size, offset, wrData
    );

    modport load (
        input  rd, size, offset, signExt,
        output rdData
    );

endinterface

`default_nettype wire

// File: hdl/apbMemPort.sv
`default_nettype none

module apbMemPort (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [memAccessPkg::ADDR_W-1:0] paddr,
    input  logic [memAccessPkg::DATA_W-1:0] pwdata,
    output logic [memAccessPkg::DATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    memReqIf.port                           req
);
    import memAccessPkg::*;

    typedef enum logic {
        IDLE,
        RD_WAIT
    } portState_t;

    portState_t                   state;
    portState_t                   stateNext;
    accessSize_t                  size;
    logic [OFFSET_MSB:OFFSET_LSB] offset;
    logic                         accessErr;
    logic                         firstAccess;
    logic                         wrStrobe;
    logic                         rdStrobe;

    ////////////////////
    // Address decode
    ////////////////////

    assign size   = accessSize_t'(paddr[SIZE_LSB +: $bits(accessSize_t)]);
    assign offset = paddr[OFFSET_MSB:OFFSET_LSB];

    assign req.size    = size;
    assign req.offset  = offset;
    assign req.signExt = paddr[SIGN_BIT];
    assign req.wordIdx = paddr[IDX_LSB +: IDX_W];
    assign req.wrData  = pwdata;

    // Alignment and size code check
    always_comb
    begin
        case (size)
            SIZE_WORD: accessErr = (offset != '0);
            SIZE_HALF: accessErr = offset[OFFSET_LSB];
            SIZE_BYTE: accessErr = 1'b0;
            SIZE_RSVD: accessErr = 1'b1;
        endcase
    end

    ////////////////////
    // Transfer sequencing
    ////////////////////

    // First access cycle of a transfer, before any wait state
    assign firstAccess = psel && penable && (state == IDLE);

    // Faulty accesses never reach the lanes
    assign wrStrobe = firstAccess && pwrite && !accessErr;
    assign rdStrobe = firstAccess && !pwrite && !accessErr;

    assign req.wr = wrStrobe;
    assign req.rd = rdStrobe;

    always_comb
    begin
        stateNext = state;
        case (state)
            IDLE:
            begin
                // Lanes and load extender need one cycle
                if (rdStrobe)
                begin
                    stateNext = RD_WAIT;
                end
            end
            RD_WAIT: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= stateNext;
        end
    end

    // Writes and errors finish at once, reads after the wait state
    assign pready  = (firstAccess && (pwrite || accessErr)) || (state == RD_WAIT);
    assign pslverr = firstAccess && accessErr;
    assign prdata  = (state == RD_WAIT) ? req.rdData : '0;

endmodule

`default_nettype wire

// File: hdl/storeAlign.sv
`default_nettype none

module storeAlign (
    memReqIf.store                          req,
    output logic [memAccessPkg::LANES-1:0]  byteEn,
    output logic [memAccessPkg::DATA_W-1:0] laneWrWord
);
    import memAccessPkg::*;

    always_comb
    begin
        byteEn     = '0;
        laneWrWord = req.wrData;

        case (req.size)
            SIZE_WORD:
            begin
                byteEn = '1;
            end
            SIZE_HALF:
            begin
                // Offset bit 1 picks the upper halfword
                if (req.offset[OFFSET_MSB])
                begin
                    byteEn     = 4'b1100;
                    laneWrWord = req.wrData << HALF_W;
                end
                else
                begin
                    byteEn = 4'b0011;
                end
            end
            SIZE_BYTE:
            begin
                // Low byte moves up to its lane
                byteEn     = LANES'(1) << req.offset;
                laneWrWord = req.wrData << (req.offset * BYTE_W);
            end
            SIZE_RSVD:
            begin
                byteEn = '0;
            end
        endcase

        // Lanes stay untouched outside a store strobe
        if (!req.wr)
        begin
            byteEn = '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/byteLaneRam.sv
`default_nettype none

module byteLaneRam (
    input  logic                           clk,
    input  logic                           we,
    input  logic [memAccessPkg::IDX_W-1:0]  addr,
    input  logic [memAccessPkg::BYTE_W-1:0] wrByte,
    output logic [memAccessPkg::BYTE_W-1:0] rdByte
);
    import memAccessPkg::*;

    logic [BYTE_W-1:0] mem [DEPTH];

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wrByte;
        end
    end

    // Read every cycle, old data on a same-address write
    always_ff @(posedge clk)
    begin
        rdByte <= mem[addr];
    end

endmodule

`default_nettype wire

// File: hdl/loadExtend.sv
`default_nettype none

module loadExtend (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [memAccessPkg::DATA_W-1:0] laneRdWord,
    memReqIf.load                           req
);
    import memAccessPkg::*;

    accessSize_t                  heldSize;
    logic [OFFSET_MSB:OFFSET_LSB] heldOffset;
    logic                         heldSignExt;
    logic [HALF_W-1:0]            selHalf;
    logic [BYTE_W-1:0]            selByte;
    logic                         fillBit;

    ////////////////////
    // Pending load
    ////////////////////

    // Lane data arrives one cycle after rd, the address may not
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            heldSize    <= SIZE_WORD;
            heldOffset  <= '0;
            heldSignExt <= 1'b0;
        end
        else if (req.rd)
        begin
            heldSize    <= req.size;
            heldOffset  <= req.offset;
            heldSignExt <= req.signExt;
        end
    end

    ////////////////////
    // Extract and extend
    ////////////////////

    assign selHalf = heldOffset[OFFSET_MSB] ? laneRdWord[HALF_W +: HALF_W]
                                            : laneRdWord[0 +: HALF_W];
    assign selByte = laneRdWord[heldOffset * BYTE_W +: BYTE_W];

    // Top bit of the selected field when sign extending
    always_comb
    begin
        if (heldSize == SIZE_HALF)
        begin
            fillBit = heldSignExt && selHalf[HALF_W-1];
        end
        else
        begin
            fillBit = heldSignExt && selByte[BYTE_W-1];
        end
    end

    always_comb
    begin
        case (heldSize)
            SIZE_WORD: req.rdData = laneRdWord;
            SIZE_HALF: req.rdData = {{(DATA_W - HALF_W){fillBit}}, selHalf};
            SIZE_BYTE: req.rdData = {{(DATA_W - BYTE_W){fillBit}}, selByte};
            SIZE_RSVD: req.rdData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/dataMemApb.sv
`default_nettype none

module dataMemApb (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [memAccessPkg::ADDR_W-1:0] paddr,
    input  logic [memAccessPkg::DATA_W-1:0] pwdata,
    output logic [memAccessPkg::DATA_W-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr
);
    import memAccessPkg::*;

    logic [LANES-1:0]  byteEn;
    logic [DATA_W-1:0] laneWrWord;
    logic [DATA_W-1:0] laneRdWord;

    memReqIf memReq ();

    apbMemPort uPort (
        .clk     (clk),
        .arstN   (arstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (memReq)
    );

    storeAlign uStore (
        .req        (memReq),
        .byteEn     (byteEn),
        .laneWrWord (laneWrWord)
    );

    loadExtend uLoad (
        .clk        (clk),
        .arstN      (arstN),
        .laneRdWord (laneRdWord),
        .req        (memReq)
    );

    ////////////////////
    // Byte lanes
    ////////////////////

    // Every lane sees the same word index
    for (genvar lane = 0; lane < LANES; lane++)
    begin : gLane
        byteLaneRam uRam (
            .clk    (clk),
            .we     (byteEn[lane]),
            .addr   (memReq.wordIdx),
            .wrByte (laneWrWord[lane*BYTE_W +: BYTE_W]),
            .rdByte (laneRdWord[lane*BYTE_W +: BYTE_W])
        );
    end

endmodule

`default_nettype wire

// File: tb/dataMemApbTb.sv
`default_nettype none

module dataMemApbTb;
    timeunit 1ns;
    timeprecision 100ps;

    import memAccessPkg::*;

    localparam int CLK_PERIOD        = 10;
    localparam int RESET_CYCLES      = 10;
    localparam int NUM_RANDOM        = 200;
    localparam int FILL_WORDS        = 16;
    localparam int CYCLES_PER_ACCESS = 4;

    // Random phase owns words 0x20 to 0x2F
    localparam logic [IDX_W-1:0] RAND_BASE = 8'h20;

    localparam logic WR  = 1'b1;
    localparam logic RD  = 1'b0;
    localparam logic SX  = 1'b1;
    localparam logic ZX  = 1'b0;
    localparam logic OK  = 1'b0;
    localparam logic ERR = 1'b1;

    typedef struct packed {
        logic              isWrite;
        logic [1:0]        size;
        logic              signExt;
        logic [1:0]        offset;
        logic [IDX_W-1:0]  idx;
        logic [DATA_W-1:0] wrData;
        logic [DATA_W-1:0] expData;
        logic              expErr;
    } access_t;

    logic              clk;
    logic              arstN;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    access_t           stimTable[$];
    logic [DATA_W-1:0] shadow [DEPTH];
    logic              tableBuilt = 1'b0;
    int                seed;

    dataMemApb dut_i (
        .clk     (clk),
        .arstN   (arstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Checking
    ////////////////////

    task automatic checkValue(input string name, input logic [DATA_W-1:0] actual,
                              input logic [DATA_W-1:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %0d ns: %s got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Errors found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Alignment rule per access size
    function automatic logic alignErr(input access_t a);
        case (a.size)
            SIZE_WORD: return a.offset != 2'd0;
            SIZE_HALF: return a.offset[0];
            SIZE_BYTE: return 1'b0;
            default:   return 1'b1;
        endcase
    endfunction

    ////////////////////
    // Shadow memory
    ////////////////////

    function automatic void shadowStore(input access_t a);
        logic [DATA_W-1:0] mask;
        logic [4:0]        shift;

        shift = {a.offset, 3'b000};
        case (a.size)
            SIZE_WORD: mask = '1;
            SIZE_HALF: mask = 32'h0000_FFFF << shift;
            default:   mask = 32'h0000_00FF << shift;
        endcase
        shadow[a.idx] = (shadow[a.idx] & ~mask) | ((a.wrData << shift) & mask);
    endfunction

    // Field moved down to bit 0, then zero or sign extended
    function automatic logic [DATA_W-1:0] shadowLoad(input access_t a);
        logic [DATA_W-1:0] field;

        field = shadow[a.idx] >> {a.offset, 3'b000};
        case (a.size)
            SIZE_HALF: return {{16{a.signExt & field[15]}}, field[15:0]};
            SIZE_BYTE: return {{24{a.signExt & field[7]}}, field[7:0]};
            default:   return field;
        endcase
    endfunction

    ////////////////////
    // APB driver
    ////////////////////

    task automatic apbTransfer(input logic isWrite, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                               output logic err, output int cycles);
        // Setup phase
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= isWrite;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        // Outputs settle by the falling edge
        @(negedge clk);
        cycles = 1;
        while (!pready)
        begin
            @(negedge clk);
            cycles++;
        end
        rdata = prdata;
        err   = pslverr;
        // Transfer completes on this edge
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic runAccess(input access_t a);
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] rdata;
        logic              err;
        int                cycles;
        int                expCycles;

        addr = '0;
        addr[SIGN_BIT] = a.signExt;
        addr[SIZE_LSB +: 2] = a.size;
        addr[IDX_LSB +: IDX_W] = a.idx;
        addr[OFFSET_MSB:OFFSET_LSB] = a.offset;
        apbTransfer(a.isWrite, addr, a.wrData, rdata, err, cycles);
        expCycles = (a.isWrite || a.expErr) ? 1 : 2;
        checkValue("prdata", rdata, a.expData);
        checkValue("pslverr", {31'b0, err}, {31'b0, a.expErr});
        checkValue("access cycles", cycles, expCycles);
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    function automatic void addEntry(input logic isWrite, input logic [1:0] size,
        input logic signExt, input logic [1:0] offset, input logic [IDX_W-1:0] idx,
        input logic [DATA_W-1:0] wrData, input logic [DATA_W-1:0] expData, input logic expErr);
        stimTable.push_back(access_t'{isWrite, size, signExt, offset, idx, wrData, expData,
                                      expErr});
    endfunction

    function automatic void buildTable();
        // Word round trips
        addEntry(WR, SIZE_WORD, ZX, 2'd0, 8'h00, 32'h1234_5678, 32'h0000_0000, OK);
        addEntry(WR, SIZE_WORD, ZX, 2'd0, 8'h01, 32'hDEAD_BEEF, 32'h0000_0000, OK);
        addEntry(WR, SIZE_WORD, ZX, 2'd0, 8'hFF, 32'hCAFE_F00D, 32'h0000_0000, OK);
        addEntry(RD, SIZE_WORD, ZX, 2'd0, 8'h00, 32'h0000_0000, 32'h1234_5678, OK);
        addEntry(RD, SIZE_WORD, SX, 2'd0, 8'h01, 32'h0000_0000, 32'hDEAD_BEEF, OK);
        addEntry(RD, SIZE_WORD, ZX, 2'd0, 8'hFF, 32'h0000_0000, 32'hCAFE_F00D, OK);
        // Upper bus bits must not leak into the halves
        addEntry(WR, SIZE_HALF, ZX, 2'd0, 8'h04, 32'hAAAA_8001, 32'h0000_0000, OK);
        addEntry(WR, SIZE_HALF, ZX, 2'd2, 8'h04, 32'h5555_F00E, 32'h0000_0000, OK);
        addEntry(RD, SIZE_WORD, ZX, 2'd0, 8'h04, 32'h0000_0000, 32'hF00E_8001, OK);
        addEntry(RD, SIZE_HALF, ZX, 2'd0, 8'h04, 32'h0000_0000, 32'h0000_8001, OK);
        addEntry(RD, SIZE_HALF, SX, 2'd0, 8'h04, 32'h0000_0000, 32'hFFFF_8001, OK);
        addEntry(RD, SIZE_HALF, ZX, 2'd2, 8'h04, 32'h0000_0000, 32'h0000_F00E, OK);
        addEntry(RD, SIZE_HALF, SX, 2'd2, 8'h04, 32'h0000_0000, 32'hFFFF_F00E, OK);
        // Bytes fill one word in order
        addEntry(WR, SIZE_BYTE, ZX, 2'd0, 8'h09, 32'h1111_1181, 32'h0000_0000, OK);
        addEntry(WR, SIZE_BYTE, ZX, 2'd1, 8'h09, 32'h2222_227F, 32'h0000_0000, OK);
        addEntry(WR, SIZE_BYTE, ZX, 2'd2, 8'h09, 32'h3333_33C3, 32'h0000_0000, OK);
        addEntry(WR, SIZE_BYTE, ZX, 2'd3, 8'h09, 32'h4444_44F4, 32'h0000_0000, OK);
        addEntry(RD, SIZE_WORD, ZX, 2'd0, 8'h09, 32'h0000_0000, 32'hF4C3_7F81, OK);
        addEntry(RD, SIZE_BYTE, SX, 2'd0, 8'h09, 32'h0000_0000, 32'hFFFF_FF81, OK);
        addEntry(RD, SIZE_BYTE, SX, 2'd1, 8'h09, 32'h0000_0000, 32'h0000_007F, OK);
        addEntry(RD, SIZE_BYTE, ZX, 2'd2, 8'h09, 32'h0000_0000, 32'h0000_00C3, OK);
        addEntry(RD, SIZE_BYTE, SX, 2'd3, 8'h09, 32'h0000_0000, 32'hFFFF_FFF4, OK);
        // Misaligned and reserved accesses leave memory as it was
        addEntry(WR, SIZE_HALF, ZX, 2'd1, 8'h00, 32'hFFFF_FFFF, 32'h0000_0000, ERR);
        addEntry(WR, SIZE_WORD, ZX, 2'd2, 8'h00, 32'hFFFF_FFFF, 32'h0000_0000, ERR);
        addEntry(WR, SIZE_RSVD, ZX, 2'd0, 8'h00, 32'hFFFF_FFFF, 32'h0000_0000, ERR);
        addEntry(RD, SIZE_HALF, SX, 2'd3, 8'h00, 32'h0000_0000, 32'h0000_0000, ERR);
        addEntry(RD, SIZE_WORD, ZX, 2'd1, 8'h00, 32'h0000_0000, 32'h0000_0000, ERR);
        addEntry(RD, SIZE_RSVD, ZX, 2'd0, 8'h00, 32'h0000_0000, 32'h0000_0000, ERR);
        addEntry(RD, SIZE_WORD, ZX, 2'd0, 8'h00, 32'h0000_0000, 32'h1234_5678, OK);
    endfunction

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        access_t           e;
        logic [DATA_W-1:0] r;

        clk        = 1'b0;
        arstN      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        seed       = 32'he482;
        buildTable();
        tableBuilt = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);

        foreach (stimTable[i])
        begin
            runAccess(stimTable[i]);
        end

        // Known contents for the random block
        for (int n = 0; n < FILL_WORDS; n++)
        begin
            e = access_t'{WR, SIZE_WORD, ZX, 2'd0, RAND_BASE + n[IDX_W-1:0], 32'h0, 32'h0, OK};
            e.wrData = $random(seed);
            shadowStore(e);
            runAccess(e);
        end

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            r = $random(seed);
            e.isWrite = r[0];
            e.size    = r[2:1];
            e.signExt = r[3];
            e.offset  = r[5:4];
            e.idx     = RAND_BASE + {4'b0, r[9:6]};
            e.wrData  = $random(seed);
            e.expErr  = alignErr(e);
            e.expData = '0;
            if (!e.expErr && e.isWrite)
            begin
                shadowStore(e);
            end
            else if (!e.expErr)
            begin
                e.expData = shadowLoad(e);
            end
            runAccess(e);
        end

        @(posedge clk);
        $display("No errors");
        $finish;
    end

    // Watchdog allows four cycles per access
    initial
    begin
        int limitNs;

        wait (tableBuilt);
        limitNs = (stimTable.size() + FILL_WORDS + NUM_RANDOM) * CYCLES_PER_ACCESS * CLK_PERIOD
                  + (RESET_CYCLES + 2) * CLK_PERIOD;
        #(limitNs);
        $display("Timeout: the run did not finish within %0d ns", limitNs);
        $display("Errors found");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: dataMemApb.f
hdl/memAccessPkg.sv
hdl/memReqIf.sv
hdl/apbMemPort.sv
hdl/storeAlign.sv
hdl/byteLaneRam.sv
hdl/loadExtend.sv
hdl/dataMemApb.sv
tb/dataMemApbTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the APB data memory testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module dataMemApbTb \
    -Mdir obj_dir \
    -f dataMemApb.f

# A failing run exits nonzero, the log decides the result
./obj_dir/VdataMemApbTb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if ! grep -q "No errors" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"
